// File: hw/mem_pkg.sv
package mem_pkg;

    // ##################################################################
    // Widths and sizes
    // ##################################################################
    localparam int data_w     = 32;
    localparam int reg_addr_w = 5;
    localparam int ram_words  = 256;
    localparam int ram_addr_w = $clog2(ram_words);  // Word index from address bits 9:2.

    // ##################################################################
    // Load type
    // ##################################################################
    // One-hot. lb sits in bit 0 and lhu in bit 4.
    typedef struct packed {
        logic lhu;
        logic lbu;
        logic lw;
        logic lh;
        logic lb;
    } load_op_t;

    // ##################################################################
    // Stage payloads
    // ##################################################################
    typedef struct packed {
        load_op_t              load_op;
        logic                  res_from_mem;   // Result comes from the RAM.
        logic                  gr_we;
        logic [reg_addr_w-1:0] dest;
        logic [data_w-1:0]     alu_result;     // Also the access address.
        logic [data_w-1:0]     pc;
    } es_to_ms_t;

    typedef struct packed {
        logic                  gr_we;
        logic [reg_addr_w-1:0] dest;
        logic [data_w-1:0]     final_result;
        logic [data_w-1:0]     pc;
    } ms_to_ws_t;

    // Forwarding record towards decode.
    typedef struct packed {
        logic                  valid;
        logic [reg_addr_w-1:0] dest;
        logic [data_w-1:0]     result;
    } fwd_t;

    // Store side of a request, already aligned by execute.
    typedef struct packed {
        logic [3:0]        wstrb;
        logic [data_w-1:0] wdata;
    } mem_req_t;

endpackage

// File: hw/stage_slot.sv
`timescale 1ns/1ps

module stage_slot #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     allowin,
    input  logic     ready_go,
    input  logic     out_allowin,
    output logic     out_valid,
    output payload_t data
);

    logic valid;

    // Take a new item when empty or when the current one leaves.
    assign allowin   = !valid || (ready_go && out_allowin);
    assign out_valid = valid && ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid <= 1'b0;
        end else if (allowin) begin
            valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && allowin) begin
            data <= in_data;
        end
    end

endmodule

// File: hw/load_align.sv
`timescale 1ns/1ps

module load_align (
    input  mem_pkg::load_op_t load_op,
    input  logic [1:0]        byte_off,
    input  logic [31:0]       rdata,
    output logic [31:0]       value
);

    logic [3:0]  lane;      // One-hot byte lane.
    logic [7:0]  byte_sel;
    logic [15:0] half_sel;
    logic [31:0] lb_val;
    logic [31:0] lbu_val;
    logic [31:0] lh_val;
    logic [31:0] lhu_val;

    always_comb begin
        lane           = 4'b0000;
        lane[byte_off] = 1'b1;
    end

    assign byte_sel = ({8{lane[0]}} & rdata[7:0])
                    | ({8{lane[1]}} & rdata[15:8])
                    | ({8{lane[2]}} & rdata[23:16])
                    | ({8{lane[3]}} & rdata[31:24]);

    // Halfwords only look at bit 1 of the offset.
    assign half_sel = byte_off[1] ? rdata[31:16] : rdata[15:0];

    assign lb_val  = {{24{byte_sel[7]}}, byte_sel};
    assign lbu_val = {24'b0, byte_sel};
    assign lh_val  = {{16{half_sel[15]}}, half_sel};
    assign lhu_val = {16'b0, half_sel};

    assign value = ({32{load_op.lb}}  & lb_val)
                 | ({32{load_op.lh}}  & lh_val)
                 | ({32{load_op.lw}}  & rdata)
                 | ({32{load_op.lbu}} & lbu_val)
                 | ({32{load_op.lhu}} & lhu_val);

endmodule

// File: hw/data_ram.sv
`timescale 1ns/1ps

module data_ram (
    input  logic             clk,
    input  logic             en,
    input  logic [31:0]      addr,
    input  mem_pkg::mem_req_t req,
    output logic [31:0]      rdata
);

    import mem_pkg::*;

    logic [data_w-1:0]     mem [ram_words];
    logic [ram_addr_w-1:0] word_addr;

    assign word_addr = addr[ram_addr_w+1:2];  // Byte address to word index.

    // Read register keeps its value between accesses.
    always_ff @(posedge clk) begin
        if (en) begin
            rdata <= mem[word_addr];  // Old word, before the write.
        end
    end

    // Byte-strobed write.
    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < 4; i++) begin
                if (req.wstrb[i]) begin
                    mem[word_addr][8*i +: 8] <= req.wdata[8*i +: 8];
                end
            end
        end
    end

endmodule

// File: hw/mem_stage.sv
`timescale 1ns/1ps

module mem_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               es_valid,
    input  mem_pkg::es_to_ms_t es_bus,
    output logic               ms_allowin,
    input  logic               ws_allowin,
    output logic               ms_to_ws_valid,
    output mem_pkg::ms_to_ws_t ms_to_ws_bus,
    output mem_pkg::fwd_t      ms_fwd,
    input  logic [31:0]        rdata
);

    import mem_pkg::*;

    es_to_ms_t         ms_bus;
    logic [data_w-1:0] mem_result;
    logic [data_w-1:0] final_result;

    // ##################################################################
    // Holding slot
    // ##################################################################
    // The RAM answers in one fixed cycle, so the stage never waits.
    stage_slot #(
        .payload_t(es_to_ms_t)
    ) ms_slot_inst (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (es_valid),
        .in_data     (es_bus),
        .allowin     (ms_allowin),
        .ready_go    (1'b1),
        .out_allowin (ws_allowin),
        .out_valid   (ms_to_ws_valid),
        .data        (ms_bus)
    );

    // ##################################################################
    // Result select
    // ##################################################################
    load_align ms_align_inst (
        .load_op  (ms_bus.load_op),
        .byte_off (ms_bus.alu_result[1:0]),
        .rdata    (rdata),
        .value    (mem_result)
    );

    assign final_result = ms_bus.res_from_mem ? mem_result : ms_bus.alu_result;

    always_comb begin
        ms_to_ws_bus.gr_we        = ms_bus.gr_we;
        ms_to_ws_bus.dest         = ms_bus.dest;
        ms_to_ws_bus.final_result = final_result;
        ms_to_ws_bus.pc           = ms_bus.pc;
    end

    // Forward bus for decode.
    always_comb begin
        ms_fwd.valid  = ms_to_ws_valid && ms_bus.gr_we;
        ms_fwd.dest   = ms_bus.dest;
        ms_fwd.result = final_result;
    end

endmodule

// File: hw/wb_stage.sv
`timescale 1ns/1ps

module wb_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               ms_to_ws_valid,
    input  mem_pkg::ms_to_ws_t ms_to_ws_bus,
    output logic               ws_allowin,
    input  logic               retire_ready,
    output logic               retire_valid,
    output mem_pkg::ms_to_ws_t retire,
    output mem_pkg::fwd_t      ws_fwd
);

    import mem_pkg::*;

    stage_slot #(
        .payload_t(ms_to_ws_t)
    ) ws_slot_inst (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (ms_to_ws_valid),
        .in_data     (ms_to_ws_bus),
        .allowin     (ws_allowin),
        .ready_go    (1'b1),
        .out_allowin (retire_ready),   // Trace sink can stall us.
        .out_valid   (retire_valid),
        .data        (retire)
    );

    always_comb begin
        ws_fwd.valid  = retire_valid && retire.gr_we;
        ws_fwd.dest   = retire.dest;
        ws_fwd.result = retire.final_result;
    end

endmodule

// File: hw/mem_wb_top.sv
`timescale 1ns/1ps

module mem_wb_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               es_valid,
    input  mem_pkg::es_to_ms_t es_bus,
    input  mem_pkg::mem_req_t  es_mem,
    output logic               ms_allowin,
    input  logic               retire_ready,
    output logic               retire_valid,
    output mem_pkg::ms_to_ws_t retire,
    output mem_pkg::fwd_t      ms_fwd,
    output mem_pkg::fwd_t      ws_fwd
);

    import mem_pkg::*;

    logic              ram_en;
    logic [data_w-1:0] ram_rdata;
    logic              ws_allowin;
    logic              ms_to_ws_valid;
    ms_to_ws_t         ms_to_ws_bus;

    // ##################################################################
    // Data RAM
    // ##################################################################
    // Access only on the edge where memory stage takes the request.
    assign ram_en = es_valid && ms_allowin;

    data_ram data_ram_inst (
        .clk   (clk),
        .en    (ram_en),
        .addr  (es_bus.alu_result),
        .req   (es_mem),
        .rdata (ram_rdata)
    );

    // ##################################################################
    // Pipeline stages
    // ##################################################################
    mem_stage mem_stage_inst (
        .clk            (clk),
        .reset          (reset),
        .es_valid       (es_valid),
        .es_bus         (es_bus),
        .ms_allowin     (ms_allowin),
        .ws_allowin     (ws_allowin),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .ms_fwd         (ms_fwd),
        .rdata          (ram_rdata)
    );

    wb_stage wb_stage_inst (
        .clk            (clk),
        .reset          (reset),
        .ms_to_ws_valid (ms_to_ws_valid),
        .ms_to_ws_bus   (ms_to_ws_bus),
        .ws_allowin     (ws_allowin),
        .retire_ready   (retire_ready),
        .retire_valid   (retire_valid),
        .retire         (retire),
        .ws_fwd         (ws_fwd)
    );

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
    parameter int period_ns = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(period_ns / 2) clk = ~clk;
        end
    end

endmodule

// File: tb/mem_wb_props.sv
`timescale 1ns/1ps

module mem_wb_props (
    input logic               clk,
    input logic               reset,
    input logic               ms_allowin,
    input logic               retire_ready,
    input logic               retire_valid,
    input mem_pkg::ms_to_ws_t retire,
    input logic               ms_to_ws_valid,
    input mem_pkg::ms_to_ws_t ms_to_ws_bus,
    input mem_pkg::fwd_t      ms_fwd,
    input mem_pkg::fwd_t      ws_fwd
);

    // A stalled retire item stays put.
    retire_hold: assert property (@(posedge clk) disable iff (reset)
        retire_valid && !retire_ready |=> retire_valid && $stable(retire))
        else $error("retire port changed while the sink stalled");

    // Empty pipeline right after a reset cycle.
    reset_state: assert property (@(posedge clk)
        reset |=> ms_allowin && !retire_valid && !ms_fwd.valid && !ws_fwd.valid)
        else $error("pipeline not empty after reset");

    ms_fwd_we: assert property (@(posedge clk) disable iff (reset)
        ms_fwd.valid |-> ms_to_ws_valid && ms_to_ws_bus.gr_we)
        else $error("ms_fwd valid without a writing instruction");

endmodule

bind mem_wb_top mem_wb_props mem_wb_props_inst (
    .clk            (clk),
    .reset          (reset),
    .ms_allowin     (ms_allowin),
    .retire_ready   (retire_ready),
    .retire_valid   (retire_valid),
    .retire         (retire),
    .ms_to_ws_valid (ms_to_ws_valid),
    .ms_to_ws_bus   (ms_to_ws_bus),
    .ms_fwd         (ms_fwd),
    .ws_fwd         (ws_fwd)
);

// File: tb/mem_wb_tb.sv
`timescale 1ns/1ps

module mem_wb_tb;

    import mem_pkg::*;

    localparam int clk_period = 100;
    localparam int alu_count  = 24;
    localparam int bp_count   = 200;
    localparam int n_requests = ram_words + alu_count + 88 + bp_count;
    localparam int timeout_ns = (n_requests * 8 + 200) * clk_period;

    logic      clk;
    logic      reset;
    logic      es_valid;
    es_to_ms_t es_bus;
    mem_req_t  es_mem;
    logic      ms_allowin;
    logic      retire_ready;
    logic      retire_valid;
    ms_to_ws_t retire;
    fwd_t      ms_fwd;
    fwd_t      ws_fwd;

    logic [data_w-1:0] ref_ram [ram_words];  // Reference copy of the RAM.
    es_to_ms_t         req_q[$];
    mem_req_t          mem_q[$];
    ms_to_ws_t         exp_q[$];             // Accepted but not yet retired.
    int                acc_step_q[$];
    logic              ms_full;
    logic              ws_full;
    logic              rand_mode;
    logic [31:0]       next_pc;
    int                idle_left;
    int                step_count;

    tb_clock #(.period_ns(clk_period)) clock_inst (.clk(clk));

    mem_wb_top mem_wb_top_inst (
        .clk          (clk),
        .reset        (reset),
        .es_valid     (es_valid),
        .es_bus       (es_bus),
        .es_mem       (es_mem),
        .ms_allowin   (ms_allowin),
        .retire_ready (retire_ready),
        .retire_valid (retire_valid),
        .retire       (retire),
        .ms_fwd       (ms_fwd),
        .ws_fwd       (ws_fwd)
    );

    // ##################################################################
    // Checks
    // ##################################################################
    task automatic stop_run(input string why);
        $display("Test failed");
        $fatal(1, "%s", why);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: %s got %h, expected %h", name, got, exp);
            stop_run("wrong handshake flag");
        end
    endtask

    task automatic check_retire(input ms_to_ws_t got, input ms_to_ws_t exp);
        if (got !== exp) begin
            $display("Error: retire got %h, expected %h", got, exp);
            stop_run("wrong retire record");
        end
    endtask

    // Dest and result only matter while the record is valid.
    task automatic check_fwd(input string name, input fwd_t got, input fwd_t exp);
        if (got.valid !== exp.valid || (exp.valid && got !== exp)) begin
            $display("Error: %s got %h, expected %h", name, got, exp);
            stop_run("wrong forward record");
        end
    endtask

    // ##################################################################
    // Reference model
    // ##################################################################
    function automatic logic [31:0] extend_load(input load_op_t op, input logic [1:0] off,
                                                input logic [31:0] word);
        logic [7:0]  b;
        logic [15:0] h;
        b = 8'(word >> (8 * off));
        h = 16'(word >> (16 * off[1]));
        if (op.lb) return {{24{b[7]}}, b};
        if (op.lbu) return {24'h0, b};
        if (op.lh) return {{16{h[15]}}, h};
        if (op.lhu) return {16'h0, h};
        return word;
    endfunction

    function automatic fwd_t fwd_of(input ms_to_ws_t item);
        fwd_t f;
        f.valid  = item.gr_we;
        f.dest   = item.dest;
        f.result = item.final_result;
        return f;
    endfunction

    function automatic load_op_t op_of(input int k);
        load_op_t op;
        op = '0;
        case (k)
            0: op.lb = 1'b1;
            1: op.lh = 1'b1;
            2: op.lw = 1'b1;
            3: op.lbu = 1'b1;
            default: op.lhu = 1'b1;
        endcase
        return op;
    endfunction

    function automatic logic [31:0] legal_addr(input load_op_t op, input logic [31:0] addr);
        logic [31:0] a;
        a = addr;
        if (op.lw) a[1:0] = 2'b00;
        if (op.lh || op.lhu) a[0] = 1'b0;
        return a;
    endfunction

    function automatic logic [31:0] fill_word(input int i);
        return 32'h9e37_79b1 * 32'(i + 1);
    endfunction

    // Old word is read first, then the strobed bytes land.
    task automatic accept_request(input es_to_ms_t b, input mem_req_t m);
        logic [ram_addr_w-1:0] idx;
        ms_to_ws_t             item;
        idx               = b.alu_result[ram_addr_w+1:2];
        item.gr_we        = b.gr_we;
        item.dest         = b.dest;
        item.pc           = b.pc;
        item.final_result = b.res_from_mem ?
            extend_load(b.load_op, b.alu_result[1:0], ref_ram[idx]) : b.alu_result;
        for (int i = 0; i < 4; i++) begin
            if (m.wstrb[i]) ref_ram[idx][8*i +: 8] = m.wdata[8*i +: 8];
        end
        exp_q.push_back(item);
        acc_step_q.push_back(step_count);
    endtask

    // ##################################################################
    // Stimulus
    // ##################################################################
    task automatic push_req(input load_op_t op, input logic gr_we, input logic [4:0] dest,
                            input logic [31:0] alu, input mem_req_t m);
        es_to_ms_t b;
        b.load_op      = op;
        b.res_from_mem = (op != '0);
        b.gr_we        = gr_we;
        b.dest         = dest;
        b.alu_result   = alu;
        b.pc           = next_pc;
        next_pc        = next_pc + 4;
        req_q.push_back(b);
        mem_q.push_back(m);
    endtask

    task automatic push_alu(input logic [4:0] dest, input logic [31:0] value, input logic we);
        push_req('0, we, dest, value, '0);
    endtask

    task automatic push_store(input logic [31:0] addr, input logic [3:0] wstrb,
                              input logic [31:0] wdata);
        push_req('0, 1'b0, 5'd0, addr, {wstrb, wdata});
    endtask

    task automatic push_load(input load_op_t op, input logic [31:0] addr,
                             input logic [4:0] dest);
        push_req(op, 1'b1, dest, addr, '0);
    endtask

    task automatic push_all_loads(input logic [31:0] addr, input logic [4:0] dest);
        push_load(op_of(2), addr, dest);
        for (int off = 0; off < 4; off += 2) begin
            push_load(op_of(1), addr + 32'(off), dest);
            push_load(op_of(4), addr + 32'(off), dest);
        end
        for (int off = 0; off < 4; off++) begin
            push_load(op_of(0), addr + 32'(off), dest);
            push_load(op_of(3), addr + 32'(off), dest);
        end
    endtask

    // Drive at the falling edge and check against the model.
    task automatic step();
        logic        ws_allow;
        logic        ms_allow;
        logic [31:0] r;
        fwd_t        ms_exp;
        fwd_t        ws_exp;
        @(negedge clk);
        r            = $urandom;
        retire_ready = rand_mode ? r[0] : 1'b1;
        if (req_q.size() > 0 && idle_left == 0) begin
            es_valid = 1'b1;
            es_bus   = req_q[0];
            es_mem   = mem_q[0];
        end else begin
            es_valid = 1'b0;
            if (idle_left > 0) idle_left--;
        end
        #1;
        ws_allow = !ws_full || retire_ready;
        ms_allow = !ms_full || ws_allow;
        check_flag("ms_allowin", ms_allowin, ms_allow);
        check_flag("retire_valid", retire_valid, ws_full);
        ms_exp = '0;
        ws_exp = '0;
        if (ws_full) begin
            check_retire(retire, exp_q[0]);
            ws_exp = fwd_of(exp_q[0]);
        end
        if (ms_full) ms_exp = fwd_of(exp_q[ws_full ? 1 : 0]);
        check_fwd("ms_fwd", ms_fwd, ms_exp);
        check_fwd("ws_fwd", ws_fwd, ws_exp);
        if (ws_full && retire_ready) begin
            if (!rand_mode && step_count - acc_step_q[0] != 2) begin
                stop_run($sformatf("pc %h retired %0d cycles after acceptance, not 2",
                                   exp_q[0].pc, step_count - acc_step_q[0]));
            end
            void'(exp_q.pop_front());
            void'(acc_step_q.pop_front());
        end
        if (es_valid && ms_allow) begin
            accept_request(req_q.pop_front(), mem_q.pop_front());
            idle_left = rand_mode ? int'(r[2:1]) : 0;
        end
        ws_full    = ws_allow ? ms_full : ws_full;
        ms_full    = ms_allow ? es_valid : ms_full;
        step_count = step_count + 1;
    endtask

    task automatic run_requests();
        while (req_q.size() > 0 || exp_q.size() > 0) begin
            step();
        end
    endtask

    // ##################################################################
    // Tests
    // ##################################################################
    task automatic test_reset();
        check_flag("ms_allowin", ms_allowin, 1'b1);
        check_flag("retire_valid", retire_valid, 1'b0);
        check_fwd("ms_fwd", ms_fwd, '0);
        check_fwd("ws_fwd", ws_fwd, '0);
    endtask

    task automatic test_alu_pass();
        rand_mode = 1'b0;
        for (int i = 0; i < alu_count; i++) begin
            push_alu(5'(i), $urandom, (i % 3) != 0);   // Every third has gr_we clear.
        end
        run_requests();
    endtask

    task automatic test_store_load();
        logic [31:0] base;
        rand_mode = 1'b0;
        for (int i = 0; i < ram_words; i++) begin
            push_store(32'(i * 4), 4'hf, fill_word(i));
        end
        run_requests();
        for (int k = 0; k < 2; k++) begin
            base = 32'h0000_0080 + 32'(k) * 32'h0000_0200;
            push_store(base, 4'hf, 32'hf1e2_83c4 + 32'(k));
            push_store(base + 4, 4'b1100, 32'h8001_5555);  // Low lanes must be ignored.
            push_store(base + 4, 4'b0011, 32'haaaa_7ffe);
            push_store(base + 8, 4'b0010, 32'h3c3c_803c);
            push_store(base + 8, 4'b1000, 32'h7f00_00ff);
            push_all_loads(base, 5'd1);
            push_all_loads(base + 4, 5'd2);
            push_all_loads(base + 8, 5'd3);
        end
        run_requests();
    endtask

    task automatic test_backpressure();
        logic [31:0] r;
        logic [31:0] a;
        load_op_t    op;
        rand_mode = 1'b1;
        for (int i = 0; i < bp_count; i++) begin
            r = $urandom;
            a = $urandom;
            case (r[1:0])
                2'd0: push_alu(r[15:11], a, r[16]);
                2'd1: push_store({22'h0, a[9:2], 2'b00}, r[7:4], r ^ a);
                default: begin
                    op = op_of(int'(r[10:8]) % 5);
                    push_load(op, legal_addr(op, {22'h0, a[9:0]}), r[15:11]);
                end
            endcase
        end
        run_requests();
    endtask

    initial begin
        void'($urandom(66));
        reset        = 1'b1;
        es_valid     = 1'b0;
        es_bus       = '0;
        es_mem       = '0;
        retire_ready = 1'b0;
        ms_full      = 1'b0;
        ws_full      = 1'b0;
        rand_mode    = 1'b0;
        next_pc      = 32'h0000_1000;
        idle_left    = 0;
        step_count   = 0;
        repeat (8) @(negedge clk);
        reset = 1'b0;
        #1;
        test_reset();
        test_alu_pass();
        test_store_load();
        test_backpressure();
        $display("Test passed");
        $finish;
    end

    // Watchdog.
    initial begin
        #(timeout_ns);
        stop_run("watchdog expired before the tests finished");
    end

endmodule

// File: verilog.f
hw/mem_pkg.sv
hw/stage_slot.sv
hw/load_align.sv
hw/data_ram.sv
hw/mem_stage.sv
hw/wb_stage.sv
hw/mem_wb_top.sv
tb/tb_clock.sv
tb/mem_wb_props.sv
tb/mem_wb_tb.sv

// File: Makefile
SRCS := $(wildcard hw/*.sv tb/*.sv)

obj_dir/Vmem_wb_tb: $(SRCS) verilog.f
	verilator --binary --timing --assert --top-module mem_wb_tb -f verilog.f

run: obj_dir/Vmem_wb_tb
	obj_dir/Vmem_wb_tb

clean:
	rm -rf obj_dir

.PHONY: run clean
